//--- Bender.yml
package:
  name: poly_synth

sources:
  - files:
      - logic/synth_pkg.sv
      - logic/midi_uart_rx.sv
      - logic/midi_parser.sv
      - logic/voice_bank.sv
      - logic/voice_mixer.sv
      - logic/poly_synth.sv
  - target: test
    files:
      - verification/synth_checker.sv
      - verification/tb_poly_synth.sv

//--- logic/midi_parser.sv
/*
 * MIDI message parser for note on, note off and the sustain pedal.
 * Running status is not supported and every channel is accepted.
 * Any other message is read and discarded.
 */
`timescale 1ns/1ps
`default_nettype none

module midi_parser (
	input  logic                   MHz10,
	input  logic                   nrst,
	input  logic                   en,
	input  logic                   byte_valid,
	input  synth_pkg::midi_byte_t  rx_byte,
	output synth_pkg::midi_event_t ev
);

	synth_pkg::parse_state_e state;
	synth_pkg::midi_byte_t   status; // last status byte
	synth_pkg::note_t        data1;  // note or controller number

	always_ff @(posedge MHz10, negedge nrst) begin
		if (!nrst) begin
			state  <= synth_pkg::ps_idle;
			status <= '0;
			data1  <= '0;
			ev     <= '0;
		end else if (en) begin
			ev.note_on     <= 1'b0; // flags are single-cycle
			ev.note_off    <= 1'b0;
			ev.sustain_chg <= 1'b0;
			if (byte_valid) begin
				if (rx_byte[7]) begin
					status <= rx_byte; // a status byte always restarts
					state  <= synth_pkg::ps_data1;
				end else begin
					case (state)
						synth_pkg::ps_data1: begin
							data1 <= rx_byte[6:0];
							state <= synth_pkg::ps_data2;
						end
						synth_pkg::ps_data2: begin
							state    <= synth_pkg::ps_idle; // no running status
							ev.note  <= data1;
							ev.value <= rx_byte[6:0];
							case (status[7:4])
								synth_pkg::st_note_on: begin
									// velocity 0 is treated as a release
									ev.note_on  <= (rx_byte[6:0] != '0);
									ev.note_off <= (rx_byte[6:0] == '0);
								end
								synth_pkg::st_note_off: ev.note_off <= 1'b1;
								synth_pkg::st_ctrl:
									ev.sustain_chg <= (data1 == synth_pkg::sustain_cc);
								default: ; // message ignored
							endcase
						end
						default: ; // stray data byte
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/midi_uart_rx.sv
/*
 * MIDI serial receiver, 8N1, LSB first, 320 clocks per bit.
 * byte_valid rises 9.5 bit times after the start edge.
 * A byte with a low stop bit is dropped without any error flag.
 */
`timescale 1ns/1ps
`default_nettype none

module midi_uart_rx (
	input  logic                  MHz10,
	input  logic                  nrst,
	input  logic                  en,
	input  logic                  serial_in,
	output logic                  byte_valid,
	output synth_pkg::midi_byte_t rx_byte
);

	logic                  sync_a;  // first synchronizer stage
	logic                  sync_b;  // second stage, safe to use
	synth_pkg::rx_state_e  state;
	synth_pkg::baud_cnt_t  cnt;     // clocks within the current bit
	logic [2:0]            bit_idx; // data bit being received

	always_ff @(posedge MHz10, negedge nrst) begin
		if (!nrst) begin
			sync_a     <= 1'b1; // idle line is high
			sync_b     <= 1'b1;
			state      <= synth_pkg::rx_idle;
			cnt        <= '0;
			bit_idx    <= '0;
			byte_valid <= 1'b0;
			rx_byte    <= '0;
		end else if (en) begin
			sync_a     <= serial_in;
			sync_b     <= sync_a;
			byte_valid <= 1'b0; // pulse by default off
			case (state)
				synth_pkg::rx_idle: begin
					cnt <= '0;
					if (!sync_b)
						state <= synth_pkg::rx_start; // falling start edge
				end
				synth_pkg::rx_start: begin
					if (cnt == synth_pkg::baud_cnt_t'(synth_pkg::rx_half_wait)) begin
						cnt     <= '0;
						bit_idx <= '0;
						// still low at mid bit means a real start bit
						state   <= sync_b ? synth_pkg::rx_idle : synth_pkg::rx_data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				synth_pkg::rx_data: begin
					if (cnt == synth_pkg::baud_cnt_t'(synth_pkg::clks_per_bit - 1)) begin
						cnt     <= '0;
						rx_byte <= {sync_b, rx_byte[7:1]}; // lsb arrives first
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= synth_pkg::rx_stop;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				synth_pkg::rx_stop: begin
					if (cnt == synth_pkg::baud_cnt_t'(synth_pkg::clks_per_bit - 1)) begin
						cnt        <= '0;
						byte_valid <= sync_b; // framing check
						state      <= synth_pkg::rx_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= synth_pkg::rx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/poly_synth.sv
/*
 * Four-voice MIDI synth top, single 10 MHz clock.
 * Output is a 10-bit unsigned sample at 40 kHz.
 * en low freezes every block, including the sample counter.
 */
`timescale 1ns/1ps
`default_nettype none

module poly_synth (
	input  logic                  MHz10,
	input  logic                  nrst,
	input  logic                  en,
	input  logic                  serial_in,
	input  logic                  clear,
	input  synth_pkg::wave_mode_e wave_mode,
	output synth_pkg::dac_t       dac_out,
	output logic                  sample_strobe
);

	logic                   byte_valid;
	synth_pkg::midi_byte_t  rx_byte;
	synth_pkg::midi_event_t ev;
	synth_pkg::voice_t      voices [synth_pkg::num_voices];
	synth_pkg::sample_cnt_t sample_cnt;
	logic                   sample_tick;

	assign sample_tick = (sample_cnt == synth_pkg::sample_cnt_t'(synth_pkg::clks_per_sample - 1));

	always_ff @(posedge MHz10, negedge nrst) begin
		if (!nrst)
			sample_cnt <= '0;
		else if (en)
			sample_cnt <= sample_tick ? '0 : sample_cnt + 1'b1; // 250 clock period
	end

	midi_uart_rx i_midi_uart_rx (.MHz10(MHz10), .nrst(nrst), .en(en), .serial_in(serial_in),
		.byte_valid(byte_valid), .rx_byte(rx_byte));

	midi_parser i_midi_parser (.MHz10(MHz10), .nrst(nrst), .en(en), .byte_valid(byte_valid),
		.rx_byte(rx_byte), .ev(ev));

	voice_bank i_voice_bank (.MHz10(MHz10), .nrst(nrst), .en(en), .ev(ev),
		.sample_tick(sample_tick), .clear(clear), .voices(voices));

	voice_mixer i_voice_mixer (.MHz10(MHz10), .nrst(nrst), .en(en), .sample_tick(sample_tick),
		.voices(voices), .wave_mode(wave_mode), .dac_out(dac_out),
		.sample_strobe(sample_strobe));

endmodule

`default_nettype wire

//--- logic/synth_pkg.sv
/*
 * Shared widths, types and timing constants for the MIDI synth.
 * All timing assumes the single 10 MHz clock MHz10.
 * Enum labels carry the prefixes wave_, ps_ and rx_.
 */
`default_nettype none

package synth_pkg;

	localparam int num_voices      = 4;
	localparam int clks_per_bit    = 320;                  // 31.25 kbaud at 10 MHz
	localparam int clks_per_sample = 250;                  // 40 kHz sample rate
	localparam int rx_half_wait    = clks_per_bit / 2 - 4; // half bit less sync and detect delay

	localparam logic [3:0] st_note_off = 4'h8;
	localparam logic [3:0] st_note_on  = 4'h9;
	localparam logic [3:0] st_ctrl     = 4'hB;
	localparam logic [6:0] sustain_cc     = 7'd64; // damper pedal controller
	localparam logic [6:0] sustain_thresh = 7'd64; // value at or above means pedal down

	typedef logic [11:0] phase_t;
	typedef logic [6:0]  note_t;
	typedef logic [6:0]  vel_t;
	typedef logic [7:0]  amp_t;
	typedef logic [9:0]  dac_t;
	typedef logic [7:0]  midi_byte_t;
	typedef logic [$clog2(clks_per_bit)-1:0]    baud_cnt_t;
	typedef logic [$clog2(clks_per_sample)-1:0] sample_cnt_t;
	typedef logic [$clog2(num_voices)-1:0]      voice_idx_t;

	typedef enum logic [1:0] {wave_saw, wave_square, wave_tri} wave_mode_e;
	typedef enum logic [1:0] {ps_idle, ps_data1, ps_data2} parse_state_e;
	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

	typedef struct packed {
		logic  note_on;
		logic  note_off;
		logic  sustain_chg;
		note_t note;  // note number, or controller number for sustain
		vel_t  value; // velocity, or controller value
	} midi_event_t;

	typedef struct packed {
		logic   gate;
		phase_t phase;
		note_t  note;
		vel_t   vel;
	} voice_t;

endpackage

`default_nettype wire

//--- logic/voice_bank.sv
/*
 * Four-voice bank with lowest-index allocation.
 * A note-on with all voices busy is dropped.
 * A voice held by the sustain pedal no longer matches note-offs.
 */
`timescale 1ns/1ps
`default_nettype none

module voice_bank (
	input  logic                   MHz10,
	input  logic                   nrst,
	input  logic                   en,
	input  synth_pkg::midi_event_t ev,
	input  logic                   sample_tick,
	input  logic                   clear,
	output synth_pkg::voice_t      voices [synth_pkg::num_voices]
);

	logic [synth_pkg::num_voices-1:0] held;       // released while pedal down
	logic                             sustain;    // pedal state
	logic                             free_found;
	synth_pkg::voice_idx_t            free_idx;   // lowest ungated voice
	logic                             match_found;
	synth_pkg::voice_idx_t            match_idx;  // lowest sounding voice on ev.note

	always_comb begin
		free_found  = 1'b0;
		free_idx    = '0;
		match_found = 1'b0;
		match_idx   = '0;
		// walk downward so the lowest index wins
		for (int i = synth_pkg::num_voices - 1; i >= 0; i--) begin
			if (!voices[i].gate) begin
				free_found = 1'b1;
				free_idx   = synth_pkg::voice_idx_t'(i);
			end
			if (voices[i].gate && !held[i] && voices[i].note == ev.note) begin
				match_found = 1'b1;
				match_idx   = synth_pkg::voice_idx_t'(i);
			end
		end
	end

	always_ff @(posedge MHz10, negedge nrst) begin
		if (!nrst) begin
			for (int i = 0; i < synth_pkg::num_voices; i++)
				voices[i] <= '0;
			held    <= '0;
			sustain <= 1'b0;
		end else if (en) begin
			if (clear) begin
				for (int i = 0; i < synth_pkg::num_voices; i++)
					voices[i].gate <= 1'b0;
				held    <= '0;
				sustain <= 1'b0;
			end else begin
				if (sample_tick) begin
					for (int i = 0; i < synth_pkg::num_voices; i++)
						if (voices[i].gate) // wraps modulo 4096
							voices[i].phase <= voices[i].phase
								+ synth_pkg::phase_t'(voices[i].note);
				end
				if (ev.note_on && free_found) begin
					voices[free_idx].gate  <= 1'b1;
					voices[free_idx].phase <= '0;
					voices[free_idx].note  <= ev.note;
					voices[free_idx].vel   <= ev.value;
					held[free_idx]         <= 1'b0;
				end
				if (ev.note_off && match_found) begin
					if (sustain)
						held[match_idx] <= 1'b1; // keeps sounding
					else
						voices[match_idx].gate <= 1'b0;
				end
				if (ev.sustain_chg) begin
					sustain <= (ev.value >= synth_pkg::sustain_thresh);
					if (ev.value < synth_pkg::sustain_thresh) begin
						// pedal up releases everything it was holding
						for (int i = 0; i < synth_pkg::num_voices; i++)
							if (held[i])
								voices[i].gate <= 1'b0;
						held <= '0;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/voice_mixer.sv
/*
 * Sequential mixer that handles one voice per clock.
 * dac_out and sample_strobe follow sample_tick by num_voices + 2 cycles.
 * Wave mode value 3 plays a saw.
 */
`timescale 1ns/1ps
`default_nettype none

module voice_mixer (
	input  logic                  MHz10,
	input  logic                  nrst,
	input  logic                  en,
	input  logic                  sample_tick,
	input  synth_pkg::voice_t     voices [synth_pkg::num_voices],
	input  synth_pkg::wave_mode_e wave_mode,
	output synth_pkg::dac_t       dac_out,
	output logic                  sample_strobe
);

	synth_pkg::voice_t     snap [synth_pkg::num_voices]; // phases from before the advance
	synth_pkg::voice_idx_t idx;     // voice being summed
	logic                  active;  // walking the voices
	logic                  latch;   // sum complete, store next cycle
	synth_pkg::dac_t       acc;
	synth_pkg::voice_t     cur;
	synth_pkg::amp_t       p;       // top 8 phase bits
	synth_pkg::amp_t       shaped;
	logic [14:0]           product; // amp times velocity
	synth_pkg::dac_t       term;

	always_ff @(posedge MHz10) begin
		if (en && sample_tick)
			snap <= voices;
	end

	assign cur = snap[idx];
	assign p   = cur.phase[11:4];

	always_comb begin
		case (wave_mode)
			synth_pkg::wave_square: shaped = p[7] ? 8'd255 : 8'd0;
			synth_pkg::wave_tri:
				if (p[7])
					shaped = synth_pkg::amp_t'(9'd511 - {p, 1'b0}); // falling half
				else
					shaped = {p[6:0], 1'b0}; // rising half
			default: shaped = p; // saw
		endcase
		product = shaped * cur.vel;
		term    = cur.gate ? synth_pkg::dac_t'(product[14:7]) : '0; // silent if ungated
	end

	always_ff @(posedge MHz10, negedge nrst) begin
		if (!nrst) begin
			idx           <= '0;
			active        <= 1'b0;
			latch         <= 1'b0;
			acc           <= '0;
			dac_out       <= '0;
			sample_strobe <= 1'b0;
		end else if (en) begin
			latch         <= 1'b0;
			sample_strobe <= 1'b0;
			if (sample_tick) begin
				idx    <= '0;
				active <= 1'b1;
				acc    <= '0;
			end else if (active) begin
				acc <= acc + term; // four voices peak at 1012, no overflow
				idx <= idx + 1'b1;
				if (idx == synth_pkg::voice_idx_t'(synth_pkg::num_voices - 1)) begin
					active <= 1'b0;
					latch  <= 1'b1;
				end
			end
			if (latch) begin
				dac_out       <= acc;
				sample_strobe <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb.f
logic/synth_pkg.sv
logic/midi_uart_rx.sv
logic/midi_parser.sv
logic/voice_bank.sv
logic/voice_mixer.sv
logic/poly_synth.sv
verification/synth_checker.sv
verification/tb_poly_synth.sv

//--- verification/synth_checker.sv
/*
 * Protocol checks bound into poly_synth.
 * Timing checks pause while en is low, since en freezes every register.
 */
`timescale 1ns/1ps
`default_nettype none

module synth_checker (
	input logic                   MHz10,
	input logic                   nrst,
	input logic                   en,
	input logic                   byte_valid,
	input synth_pkg::midi_event_t ev,
	input logic                   sample_tick,
	input logic                   sample_strobe
);

	int error_count = 0; // assertion failures so far

	ev_flags_exclusive: assert property (@(posedge MHz10) disable iff (!nrst)
		$onehot0({ev.note_on, ev.note_off, ev.sustain_chg}))
		else begin
			$error("more than one event flag set in one cycle");
			error_count++;
		end

	byte_valid_single: assert property (@(posedge MHz10) disable iff (!nrst || !en)
		byte_valid |=> !byte_valid)
		else begin
			$error("byte_valid high for more than one cycle");
			error_count++;
		end

	// mixer latency is fixed at one cycle per voice plus two
	strobe_after_tick: assert property (@(posedge MHz10) disable iff (!nrst || !en)
		sample_tick |-> ##(synth_pkg::num_voices + 2) sample_strobe)
		else begin
			$error("sample_strobe missing after sample_tick");
			error_count++;
		end

	strobe_needs_tick: assert property (@(posedge MHz10) disable iff (!nrst || !en)
		sample_strobe |-> $past(sample_tick, synth_pkg::num_voices + 2))
		else begin
			$error("sample_strobe without a sample_tick before it");
			error_count++;
		end

endmodule

bind poly_synth synth_checker i_synth_checker (.MHz10(MHz10), .nrst(nrst), .en(en),
	.byte_valid(byte_valid), .ev(ev), .sample_tick(sample_tick),
	.sample_strobe(sample_strobe));

`default_nettype wire

//--- verification/tb_poly_synth.sv
/*
 * Testbench for poly_synth against a reference model of the voice rules.
 * The last byte of each message starts right after a sample strobe, so the
 * event lands between the same two strobes in the DUT and in the model.
 * Stops at the first mismatch.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_poly_synth;

	logic                  MHz10;
	logic                  nrst;
	logic                  en;
	logic                  serial_in;
	logic                  clear;
	synth_pkg::wave_mode_e wave_mode;
	synth_pkg::dac_t       dac_out;
	logic                  sample_strobe;

	int unsigned     lcg_state = 51132;
	bit              m_gate  [synth_pkg::num_voices]; // model voices
	bit              m_held  [synth_pkg::num_voices]; // released under pedal
	int              m_phase [synth_pkg::num_voices];
	int              m_note  [synth_pkg::num_voices];
	int              m_vel   [synth_pkg::num_voices];
	bit              m_sustain;
	int              compared = 0; // strobes checked
	int              chord [4];
	int              last_expected; // model sample at the last strobe

	poly_synth i_poly_synth (.MHz10(MHz10), .nrst(nrst), .en(en), .serial_in(serial_in),
		.clear(clear), .wave_mode(wave_mode), .dac_out(dac_out),
		.sample_strobe(sample_strobe));

	always #50 MHz10 = ~MHz10; // 10 MHz

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 16; // upper bits are the better ones
	endfunction

	// expected dac word from the model phases before the advance
	function automatic int expected_sum(input synth_pkg::wave_mode_e mode);
		int sum;
		int p;
		int amp;
		sum = 0;
		for (int v = 0; v < synth_pkg::num_voices; v++) begin
			p = m_phase[v] / 16; // top 8 of 12 phase bits
			if (mode == synth_pkg::wave_square)
				amp = (p >= 128) ? 255 : 0;
			else if (mode == synth_pkg::wave_tri)
				amp = (p < 128) ? 2 * p : 511 - 2 * p;
			else
				amp = p;
			if (m_gate[v])
				sum += (amp * m_vel[v]) / 128;
		end
		return sum;
	endfunction

	task automatic model_note_off(input int note);
		int hit;
		hit = -1;
		for (int i = 0; i < synth_pkg::num_voices; i++)
			if (hit < 0 && m_gate[i] && !m_held[i] && m_note[i] == note)
				hit = i; // lowest sounding match
		if (hit >= 0) begin
			if (m_sustain)
				m_held[hit] = 1'b1;
			else
				m_gate[hit] = 1'b0;
		end
	endtask

	task automatic model_note_on(input int note, input int vel);
		int slot;
		slot = -1;
		for (int i = 0; i < synth_pkg::num_voices; i++)
			if (slot < 0 && !m_gate[i])
				slot = i;
		if (vel == 0) begin
			model_note_off(note); // zero velocity is a release
		end else if (slot >= 0) begin // all busy means dropped
			m_gate[slot]  = 1'b1;
			m_held[slot]  = 1'b0;
			m_phase[slot] = 0;
			m_note[slot]  = note;
			m_vel[slot]   = vel;
		end
	endtask

	task automatic model_sustain(input int value);
		m_sustain = (value >= 64);
		for (int i = 0; i < synth_pkg::num_voices; i++) begin
			if (value < 64 && m_held[i]) begin
				m_gate[i] = 1'b0; // pedal up
				m_held[i] = 1'b0;
			end
		end
	endtask

	task automatic model_clear();
		m_sustain = 1'b0;
		for (int i = 0; i < synth_pkg::num_voices; i++) begin
			m_gate[i] = 1'b0;
			m_held[i] = 1'b0;
		end
	endtask

	// returns on the edge that ends the strobe cycle
	task automatic wait_strobe();
		int cycles;
		cycles = 0;
		@(posedge MHz10);
		while (!sample_strobe && cycles < 1000) begin
			@(posedge MHz10);
			cycles++;
		end
		assert (sample_strobe) else fail_run("timeout: no sample_strobe within 1000 cycles");
	endtask

	task automatic send_byte(input logic [7:0] b);
		serial_in <= 1'b0; // start bit
		repeat (synth_pkg::clks_per_bit) @(posedge MHz10);
		for (int i = 0; i < 8; i++) begin
			serial_in <= b[i]; // lsb first
			repeat (synth_pkg::clks_per_bit) @(posedge MHz10);
		end
		serial_in <= 1'b1; // stop bit
		repeat (synth_pkg::clks_per_bit) @(posedge MHz10);
	endtask

	task automatic send_msg(input logic [7:0] status, input logic [7:0] d1,
		input logic [7:0] d2);
		send_byte(status);
		send_byte(d1);
		wait_strobe(); // aligns the event with the sample grid
		send_byte(d2);
	endtask

	task automatic note_on(input int note, input int vel);
		send_msg(8'h90 | 8'(lcg_next() % 16), 8'(note), 8'(vel)); // any channel
		model_note_on(note, vel);
	endtask

	task automatic note_off(input int note);
		send_msg(8'h80, 8'(note), 8'd64);
		model_note_off(note);
	endtask

	task automatic sustain(input int value);
		send_msg(8'hB0, 8'd64, 8'(value)); // damper controller
		model_sustain(value);
	endtask

	task automatic set_wave(input synth_pkg::wave_mode_e mode);
		wait_strobe();
		wave_mode <= mode;
	endtask

	task automatic pulse_clear();
		wait_strobe();
		clear <= 1'b1;
		@(posedge MHz10);
		clear <= 1'b0;
		model_clear();
	endtask

	task automatic expect_silence();
		wait_strobe();
		assert (dac_out == '0) else
			fail_run($sformatf("FAIL time %0t dac_out expected 0 actual %0d", $time, dac_out));
	endtask

	task automatic freeze(input int cycles);
		wait_strobe();
		en <= 1'b0;
		repeat (cycles) begin
			@(negedge MHz10);
			assert (int'(dac_out) == last_expected) else
				fail_run($sformatf("FAIL time %0t dac_out expected %0d actual %0d",
					$time, last_expected, dac_out));
			assert (!sample_strobe) else fail_run("sample_strobe pulsed while en was low");
		end
		@(posedge MHz10);
		en <= 1'b1;
	endtask

	always @(negedge MHz10) begin : compare_sample
		if (nrst && sample_strobe) begin
			last_expected = expected_sum(wave_mode);
			assert (int'(dac_out) == last_expected) else
				fail_run($sformatf("FAIL time %0t dac_out expected %0d actual %0d",
					$time, last_expected, dac_out));
			compared++;
			for (int i = 0; i < synth_pkg::num_voices; i++)
				if (m_gate[i])
					m_phase[i] = (m_phase[i] + m_note[i]) % 4096; // advance after tick
		end
	end

	always @(negedge MHz10) begin : watch_checker
		assert (i_poly_synth.i_synth_checker.error_count == 0) else
			fail_run("a protocol assertion in synth_checker failed");
	end

	initial begin
		MHz10     = 1'b0;
		nrst      = 1'b0;
		en        = 1'b1;
		serial_in = 1'b1; // idle line
		clear     = 1'b0;
		wave_mode = synth_pkg::wave_saw;
		repeat (2) @(posedge MHz10);
		nrst <= 1'b1;

		repeat (8) wait_strobe(); // no notes yet
		expect_silence();

		note_on(60, 127); // saw ramp
		repeat (40) wait_strobe();
		note_off(60);
		repeat (3) wait_strobe();
		expect_silence();

		for (int m = 0; m < 3; m++) begin
			set_wave(synth_pkg::wave_mode_e'(m));
			for (int i = 0; i < 4; i++) begin
				chord[i] = 24 + int'(lcg_next() % 72);
				note_on(chord[i], 1 + int'(lcg_next() % 127));
			end
			note_on(chord[0] + 1, 100); // fifth note, no voice left
			repeat (30) wait_strobe();
			for (int i = 0; i < 4; i++)
				note_off(chord[i]);
			expect_silence();
		end

		set_wave(synth_pkg::wave_tri);
		sustain(127);
		note_on(50, 90);
		note_on(57, 70);
		note_off(50);
		note_on(57, 0); // release by velocity 0
		repeat (20) wait_strobe(); // both still sounding
		sustain(0);
		repeat (2) wait_strobe();
		expect_silence();

		set_wave(synth_pkg::wave_square);
		note_on(64, 110);
		note_on(71, 80);
		repeat (20) wait_strobe();
		pulse_clear();
		repeat (2) wait_strobe();
		expect_silence();
		note_on(40, 127);
		note_on(45, 60);
		repeat (10) wait_strobe();
		freeze(2000);
		repeat (20) wait_strobe(); // phases pick up where they stopped
		pulse_clear();
		expect_silence();

		if (compared > 100) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			fail_run($sformatf("only %0d samples were compared", compared));
		end
	end

endmodule

`default_nettype wire
